//--- list.f
src/isr_dma_pkg.sv
src/completion_queue.sv
src/isr_dma_arbiter.sv
src/isr_dma_top.sv
tests/isr_dma_checker.sv
tests/tb_isr_dma.sv

//--- run.sh
#!/bin/sh
# Build the ISR DMA testbench with Verilator and run it from the project root

verilator --binary --timing -f list.f --top-module tb_isr_dma -o sim_isr_dma \
  || exit 1

out=$(./obj_dir/sim_isr_dma)
echo "$out"

# Result is taken from the simulator output
echo "$out" | grep -q "Simulation PASSED" && exit 0 || exit 1

//--- src/completion_queue.sv
`timescale 1ns/1ps

module completion_queue #(
  parameter int DEPTH = 4
) (
  input  logic                  aclk,
  input  logic                  aresetn,

  // Write side, one record per accepted ctl request
  input  logic                  push,
  input  isr_dma_pkg::cpl_rec_t push_data,
  output logic                  not_full,

  // Read side, popped by the done strobe
  input  logic                  pop,
  output isr_dma_pkg::cpl_rec_t head
);

  // Pointer width kept at one bit or more for a single slot
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  // Slot index where the pointers wrap
  localparam logic [PTR_BITS-1:0] LAST_SLOT = PTR_BITS'(DEPTH - 1);
  localparam logic [CNT_BITS-1:0] FULL_CNT  = CNT_BITS'(DEPTH);

  // --------------------------------------------------------------------------
  // Storage and state
  // --------------------------------------------------------------------------

  isr_dma_pkg::cpl_rec_t mem [DEPTH];

  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;

  logic do_push;
  logic do_pop;

  // Room left while occupancy is below depth
  assign not_full = (count != FULL_CNT);

  // Push on full and pop on empty are dropped
  assign do_push  = push && not_full;
  assign do_pop   = pop && (count != '0);

  // Oldest entry, valid from the cycle after its push
  assign head     = mem[rd_ptr];

  // Record write
  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // --------------------------------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------------------------------

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end

      // Simultaneous push and pop leave the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/isr_dma_arbiter.sv
`timescale 1ns/1ps

module isr_dma_arbiter #(
  parameter int RDWR        = 0,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                                               aclk,
  input  logic                                               aresetn,

  // Region side
  input  logic [isr_dma_pkg::N_REGIONS-1:0]                  req_valid,
  input  isr_dma_pkg::isr_req_t [isr_dma_pkg::N_REGIONS-1:0] req,
  output logic [isr_dma_pkg::N_REGIONS-1:0]                  req_ready,
  output isr_dma_pkg::isr_rsp_t [isr_dma_pkg::N_REGIONS-1:0] rsp,

  // Host DMA channel
  output logic                                               host_valid,
  output isr_dma_pkg::dma_req_t                              host_req,
  input  logic                                               host_ready,
  input  logic                                               host_done,

  // Card DMA channel
  output logic                                               card_valid,
  output isr_dma_pkg::dma_req_t                              card_req,
  input  logic                                               card_ready,
  input  logic                                               card_done
);

  // Round-robin pointer and current winner
  isr_dma_pkg::region_id_t rr;
  isr_dma_pkg::region_id_t winner;
  logic                    any_valid;

  // Both channels and the queue can take a request
  logic                    chan_ready;
  logic                    grant_ok;

  isr_dma_pkg::isr_req_t   win_req;

  // Completion path
  logic                    done_sel;
  logic                    q_push;
  logic                    q_not_full;
  isr_dma_pkg::cpl_rec_t   q_push_data;
  isr_dma_pkg::cpl_rec_t   q_head;

  // Region index base+offset, wrapped once
  function automatic isr_dma_pkg::region_id_t region_at(
    input isr_dma_pkg::region_id_t base,
    input int                      offset
  );
    int sum;
    sum = int'(base) + offset;
    if (sum >= isr_dma_pkg::N_REGIONS) begin
      sum = sum - isr_dma_pkg::N_REGIONS;
    end
    return isr_dma_pkg::region_id_t'(sum);
  endfunction

  // --------------------------------------------------------------------------
  // Round-robin scan
  // --------------------------------------------------------------------------

  // First valid region at or after rr
  always_comb begin
    any_valid = 1'b0;
    winner    = rr;
    for (int i = 0; i < isr_dma_pkg::N_REGIONS; i++) begin
      if (!any_valid && req_valid[region_at(rr, i)]) begin
        any_valid = 1'b1;
        winner    = region_at(rr, i);
      end
    end
  end

  assign chan_ready = host_ready & card_ready;

  // Any stall source holds every grant
  assign grant_ok   = any_valid & chan_ready & q_not_full;

  // Only the winner sees ready
  always_comb begin
    req_ready         = '0;
    req_ready[winner] = grant_ok;
  end

  // Pointer steps by one per transfer, not past the winner
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rr <= '0;
    end else if (grant_ok) begin
      if (rr == isr_dma_pkg::region_id_t'(isr_dma_pkg::N_REGIONS - 1)) begin
        rr <= '0;
      end else begin
        rr <= rr + 1'b1;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Channel fan-out
  // --------------------------------------------------------------------------

  assign win_req        = req[winner];

  // Shared valid for both engines
  assign host_valid     = grant_ok;
  assign card_valid     = grant_ok;

  // Host side gets host address
  assign host_req.paddr = win_req.paddr_host;
  assign host_req.len   = win_req.len;
  assign host_req.ctl   = win_req.ctl;

  // Card side gets card address
  assign card_req.paddr = win_req.paddr_card;
  assign card_req.len   = win_req.len;
  assign card_req.ctl   = win_req.ctl;

  // --------------------------------------------------------------------------
  // Completions
  // --------------------------------------------------------------------------

  // Done comes from the engine that finishes the transfer
  assign done_sel = (RDWR == 0) ? card_done : host_done;

  // Record only requests that want a completion
  assign q_push             = grant_ok & win_req.ctl;
  assign q_push_data.stream = win_req.stream;
  assign q_push_data.dest   = win_req.dest;
  assign q_push_data.region = winner;
  assign q_push_data.pid    = win_req.pid;

  completion_queue #(
    .DEPTH     (QUEUE_DEPTH)
  ) i_cpl_queue (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .push      (q_push),
    .push_data (q_push_data),
    .not_full  (q_not_full),
    .pop       (done_sel),
    .head      (q_head)
  );

  // Steer done to the region held at the queue head
  always_comb begin
    for (int i = 0; i < isr_dma_pkg::N_REGIONS; i++) begin
      rsp[i] = '0;
      if (done_sel && (q_head.region == isr_dma_pkg::region_id_t'(i))) begin
        rsp[i].done   = 1'b1;
        rsp[i].pid    = q_head.pid;
        rsp[i].dest   = q_head.dest;
        rsp[i].stream = q_head.stream;
      end
    end
  end

endmodule

//--- src/isr_dma_pkg.sv
package isr_dma_pkg;

  // --------------------------------------------------------------------------
  // Sizing
  // --------------------------------------------------------------------------

  // TLB regions that raise ISR DMA requests
  localparam int N_REGIONS      = 4;
  localparam int N_REGIONS_BITS = 2;

  // Request field widths
  localparam int PID_BITS       = 6;
  localparam int DEST_BITS      = 4;
  localparam int PADDR_BITS     = 48;
  localparam int LEN_BITS       = 28;

  typedef logic [N_REGIONS_BITS-1:0] region_id_t;
  typedef logic [PID_BITS-1:0]       pid_t;
  typedef logic [DEST_BITS-1:0]      dest_t;
  typedef logic [PADDR_BITS-1:0]     paddr_t;
  typedef logic [LEN_BITS-1:0]       len_t;

  // --------------------------------------------------------------------------
  // Bundles
  // --------------------------------------------------------------------------

  // Region request, both physical addresses of one transfer
  typedef struct packed {
    paddr_t paddr_host;
    paddr_t paddr_card;
    len_t   len;
    logic   ctl;     // completion wanted
    pid_t   pid;
    dest_t  dest;
    logic   stream;
  } isr_req_t;

  // Completion back to the issuing region
  typedef struct packed {
    logic  done;
    pid_t  pid;
    dest_t dest;
    logic  stream;
  } isr_rsp_t;

  // Request to a single DMA channel
  typedef struct packed {
    paddr_t paddr;
    len_t   len;
    logic   ctl;
  } dma_req_t;

  // Queued completion, kept in issue order
  typedef struct packed {
    logic       stream;
    dest_t      dest;
    region_id_t region;
    pid_t       pid;
  } cpl_rec_t;

endpackage

//--- src/isr_dma_top.sv
`timescale 1ns/1ps

module isr_dma_top #(
  // 0 for reads finishing on the card engine, 1 for writes on the host engine
  parameter int RDWR        = 0,
  // Outstanding completions allowed
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                                               aclk,
  input  logic                                               aresetn,

  // --------------------------------------------------------------------------
  // Region ports
  // --------------------------------------------------------------------------
  input  logic [isr_dma_pkg::N_REGIONS-1:0]                  req_valid,
  input  isr_dma_pkg::isr_req_t [isr_dma_pkg::N_REGIONS-1:0] req,
  output logic [isr_dma_pkg::N_REGIONS-1:0]                  req_ready,
  output isr_dma_pkg::isr_rsp_t [isr_dma_pkg::N_REGIONS-1:0] rsp,

  // --------------------------------------------------------------------------
  // Host/card DMA pair
  // --------------------------------------------------------------------------
  output logic                                               host_valid,
  output isr_dma_pkg::dma_req_t                              host_req,
  input  logic                                               host_ready,
  input  logic                                               host_done,

  output logic                                               card_valid,
  output isr_dma_pkg::dma_req_t                              card_req,
  input  logic                                               card_ready,
  input  logic                                               card_done
);

  // One arbiter per direction
  isr_dma_arbiter #(
    .RDWR        (RDWR),
    .QUEUE_DEPTH (QUEUE_DEPTH)
  ) i_arbiter (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .req_valid   (req_valid),
    .req         (req),
    .req_ready   (req_ready),
    .rsp         (rsp),
    .host_valid  (host_valid),
    .host_req    (host_req),
    .host_ready  (host_ready),
    .host_done   (host_done),
    .card_valid  (card_valid),
    .card_req    (card_req),
    .card_ready  (card_ready),
    .card_done   (card_done)
  );

endmodule

//--- tests/isr_dma_checker.sv
`timescale 1ns/1ps

module isr_dma_checker #(
  parameter int RDWR        = 0,
  parameter int QUEUE_DEPTH = 4
) (
  input  logic                                               aclk,
  input  logic                                               aresetn,
  input  logic [isr_dma_pkg::N_REGIONS-1:0]                  req_valid,
  input  isr_dma_pkg::isr_req_t [isr_dma_pkg::N_REGIONS-1:0] req,
  input  logic [isr_dma_pkg::N_REGIONS-1:0]                  req_ready,
  input  isr_dma_pkg::isr_rsp_t [isr_dma_pkg::N_REGIONS-1:0] rsp,
  input  logic                                               host_valid,
  input  isr_dma_pkg::dma_req_t                              host_req,
  input  logic                                               host_ready,
  input  logic                                               host_done,
  input  logic                                               card_valid,
  input  isr_dma_pkg::dma_req_t                              card_req,
  input  logic                                               card_ready,
  input  logic                                               card_done,
  output int                                                 error_count
);

  localparam int N = isr_dma_pkg::N_REGIONS;

  // Reference round-robin pointer and in-order completion model
  int                    rr_m;
  isr_dma_pkg::cpl_rec_t cpl_q [$];

  initial begin
    error_count = 0;
    rr_m        = 0;
  end

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t ns: %s", $time, msg);
    error_count++;
  endtask

  // --------------------------------------------------------------------------
  // Sampled on the rising edge, inputs settled since the falling edge
  // --------------------------------------------------------------------------

  always @(posedge aclk) begin
    int                    win;
    logic                  any;
    logic                  grant;
    logic                  done;
    logic [N-1:0]          exp_ready;
    isr_dma_pkg::dma_req_t exp_host;
    isr_dma_pkg::dma_req_t exp_card;
    isr_dma_pkg::isr_rsp_t exp_rsp;
    isr_dma_pkg::cpl_rec_t rec;
    int                    idx;

    if (!aresetn) begin
      rr_m = 0;
      cpl_q.delete();
      if (req_ready !== '0 || host_valid !== 1'b0 || card_valid !== 1'b0) begin
        report_mismatch("grant or channel valid during reset");
      end
      for (int i = 0; i < N; i++) begin
        if (rsp[i].done !== 1'b0) begin
          report_mismatch($sformatf("rsp[%0d].done high during reset", i));
        end
      end
    end else begin
      // Scan from rr with wraparound
      any = 1'b0;
      win = rr_m;
      for (int i = 0; i < N; i++) begin
        idx = (rr_m + i) % N;
        if (!any && req_valid[idx]) begin
          any = 1'b1;
          win = idx;
        end
      end

      // Any stall source holds every grant
      grant     = any && host_ready && card_ready && (cpl_q.size() < QUEUE_DEPTH);
      exp_ready = '0;
      if (grant) begin
        exp_ready[win] = 1'b1;
      end

      if (req_ready !== exp_ready) begin
        report_mismatch($sformatf("req_ready %b, expected %b", req_ready, exp_ready));
      end
      if (host_valid !== grant || card_valid !== grant) begin
        report_mismatch($sformatf("host_valid %b card_valid %b, expected %b",
                                  host_valid, card_valid, grant));
      end

      // Fan-out of the winner to both engines
      if (grant) begin
        exp_host.paddr = req[win].paddr_host;
        exp_host.len   = req[win].len;
        exp_host.ctl   = req[win].ctl;
        exp_card.paddr = req[win].paddr_card;
        exp_card.len   = req[win].len;
        exp_card.ctl   = req[win].ctl;
        if (host_req !== exp_host) begin
          report_mismatch($sformatf("host_req %h, expected %h", host_req, exp_host));
        end
        if (card_req !== exp_card) begin
          report_mismatch($sformatf("card_req %h, expected %h", card_req, exp_card));
        end
      end

      // Done of the engine finishing the transfer
      done = (RDWR == 0) ? card_done : host_done;
      if (done && cpl_q.size() == 0) begin
        $display("Error at %0t ns: done strobe with no outstanding completion", $time);
        error_count++;
      end else begin
        rec = (cpl_q.size() > 0) ? cpl_q[0] : '0;
        for (int i = 0; i < N; i++) begin
          exp_rsp = '0;
          if (done && int'(rec.region) == i) begin
            exp_rsp.done   = 1'b1;
            exp_rsp.pid    = rec.pid;
            exp_rsp.dest   = rec.dest;
            exp_rsp.stream = rec.stream;
          end
          if (rsp[i] !== exp_rsp) begin
            report_mismatch($sformatf("rsp[%0d] %h, expected %h", i, rsp[i], exp_rsp));
          end
        end
        if (done) begin
          void'(cpl_q.pop_front());
        end
      end

      // Model update, pushed behind the popped head
      if (grant) begin
        if (req[win].ctl) begin
          rec.stream = req[win].stream;
          rec.dest   = req[win].dest;
          rec.region = isr_dma_pkg::region_id_t'(win);
          rec.pid    = req[win].pid;
          cpl_q.push_back(rec);
        end
        rr_m = (rr_m + 1) % N;
      end
    end
  end

endmodule

//--- tests/isr_dma_tests.txt
# valid(hex) host_ready card_ready host_done card_done, then regions 0..3 each:
# ctl pid(hex) dest(hex) stream addr(hex, 24 bit) len(hex, 16 bit)
F 1 1 0 0  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
F 1 1 0 0  0 01 1 0 000110 0041  0 02 2 1 001210 0081  0 03 3 0 002310 00c1  0 04 4 1 003410 0101
F 1 1 0 0  0 01 1 0 000120 0042  0 02 2 1 001220 0082  0 03 3 0 002320 00c2  0 04 4 1 003420 0102
F 1 1 0 0  0 01 1 0 000130 0043  0 02 2 1 001230 0083  0 03 3 0 002330 00c3  0 04 4 1 003430 0103
F 1 1 0 0  0 01 1 0 000140 0044  0 02 2 1 001240 0084  0 03 3 0 002340 00c4  0 04 4 1 003440 0104
1 1 1 0 0  0 01 1 0 000150 0045  0 02 2 1 001250 0085  0 03 3 0 002350 00c5  0 04 4 1 003450 0105
2 1 1 0 0  0 01 1 0 000160 0046  0 02 2 1 001260 0086  0 03 3 0 002360 00c6  0 04 4 1 003460 0106
A 1 1 0 0  0 01 1 0 000170 0047  0 02 2 1 001270 0087  0 03 3 0 002370 00c7  0 04 4 1 003470 0107
F 0 1 0 0  0 01 1 0 000180 0048  0 02 2 1 001280 0088  0 03 3 0 002380 00c8  0 04 4 1 003480 0108
F 1 0 0 0  0 01 1 0 000190 0049  0 02 2 1 001290 0089  0 03 3 0 002390 00c9  0 04 4 1 003490 0109
0 1 1 0 0  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
4 1 1 0 0  0 01 1 0 000100 0040  0 02 2 1 001200 0080  1 2a 5 1 0023a0 00d0  0 04 4 1 003400 0100
1 1 1 0 1  1 11 6 0 0001b0 0050  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
0 1 1 1 1  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
0 1 1 1 0  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
F 1 1 0 0  1 21 7 1 0001c0 0060  1 22 8 0 0012c0 0061  1 23 9 1 0023c0 0062  1 24 a 0 0034c0 0063
F 1 1 0 0  1 25 7 1 0001d0 0064  1 26 8 0 0012d0 0065  1 27 9 1 0023d0 0066  1 28 a 0 0034d0 0067
F 1 1 0 0  1 29 7 1 0001e0 0068  1 2a 8 0 0012e0 0069  1 2b 9 1 0023e0 006a  1 2c a 0 0034e0 006b
F 1 1 0 0  1 2d 7 1 0001f0 006c  1 2e 8 0 0012f0 006d  1 2f 9 1 0023f0 006e  1 30 a 0 0034f0 006f
F 1 1 0 0  1 31 b 0 000200 0070  1 32 c 1 001300 0071  1 33 d 0 002400 0072  1 34 e 1 003500 0073
F 1 1 0 1  1 31 b 0 000200 0070  1 32 c 1 001300 0071  1 33 d 0 002400 0072  1 34 e 1 003500 0073
F 1 1 0 0  1 35 b 0 000210 0074  1 36 c 1 001310 0075  1 37 d 0 002410 0076  1 38 e 1 003510 0077
0 1 1 0 1  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
0 1 1 0 1  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
0 1 1 0 1  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
0 1 1 0 1  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
0 1 1 0 0  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
3 1 1 0 0  0 3a 1 1 000220 0078  1 3b 2 0 001320 0079  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
3 1 1 0 0  0 3a 1 1 000220 0078  1 3b 2 0 001320 0079  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
0 0 1 0 1  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100
0 1 1 0 0  0 01 1 0 000100 0040  0 02 2 1 001200 0080  0 03 3 0 002300 00c0  0 04 4 1 003400 0100

//--- tests/tb_isr_dma.sv
`timescale 1ns/1ps

module tb_isr_dma;

  localparam int N             = isr_dma_pkg::N_REGIONS;
  localparam int CLK_PERIOD    = 8;
  localparam int RESET_CYCLES  = 10;
  localparam int RANDOM_CYCLES = 200;
  localparam int MAX_VECTORS   = 256;
  localparam int N_FIELDS      = 29;

  logic                                               aclk;
  logic                                               aresetn;
  logic [N-1:0]                                       req_valid;
  isr_dma_pkg::isr_req_t [N-1:0]                      req;
  logic [N-1:0]                                       req_ready;
  isr_dma_pkg::isr_rsp_t [N-1:0]                      rsp;
  logic                                               host_valid;
  isr_dma_pkg::dma_req_t                              host_req;
  logic                                               host_ready;
  logic                                               host_done;
  logic                                               card_valid;
  isr_dma_pkg::dma_req_t                              card_req;
  logic                                               card_ready;
  logic                                               card_done;

  // Vectors from the data file
  logic [N-1:0]          vec_valid [MAX_VECTORS];
  logic [3:0]            vec_ctrl  [MAX_VECTORS];
  isr_dma_pkg::isr_req_t vec_req   [MAX_VECTORS][N];
  int                    n_vec;
  logic                  load_done;

  int                    checker_errors;
  int                    outstanding;
  int                    seed;

  initial begin
    aclk      = 1'b0;
    aresetn   = 1'b0;
    req_valid = '0;
    req       = '0;
    host_ready = 1'b0;
    card_ready = 1'b0;
    host_done = 1'b0;
    card_done = 1'b0;
    n_vec     = 0;
    load_done = 1'b0;
    seed      = 32'hcb13_4b23;
  end

  always #(CLK_PERIOD / 2) aclk = ~aclk;

  isr_dma_top #(
    .RDWR        (0),
    .QUEUE_DEPTH (4)
  ) i_dut (
    .aclk(aclk), .aresetn(aresetn),
    .req_valid(req_valid), .req(req), .req_ready(req_ready), .rsp(rsp),
    .host_valid(host_valid), .host_req(host_req),
    .host_ready(host_ready), .host_done(host_done),
    .card_valid(card_valid), .card_req(card_req),
    .card_ready(card_ready), .card_done(card_done)
  );

  isr_dma_checker #(
    .RDWR        (0),
    .QUEUE_DEPTH (4)
  ) i_checker (
    .aclk(aclk), .aresetn(aresetn),
    .req_valid(req_valid), .req(req), .req_ready(req_ready), .rsp(rsp),
    .host_valid(host_valid), .host_req(host_req),
    .host_ready(host_ready), .host_done(host_done),
    .card_valid(card_valid), .card_req(card_req),
    .card_ready(card_ready), .card_done(card_done),
    .error_count(checker_errors)
  );

  // Outstanding ctl transfers, so card dones never hit an empty queue
  always @(posedge aclk) begin
    if (!aresetn) begin
      outstanding = 0;
    end else begin
      for (int i = 0; i < N; i++) begin
        if (req_valid[i] && req_ready[i] && req[i].ctl) begin
          outstanding++;
        end
      end
      if (card_done && outstanding > 0) begin
        outstanding--;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------

  task automatic load_vectors(output logic ok);
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f [N_FIELDS];
    int          b;

    ok = 1'b0;
    fd = $fopen("tests/isr_dma_tests.txt", "r");
    if (fd == 0) begin
      return;
    end
    while (!$feof(fd) && n_vec < MAX_VECTORS) begin
      cnt = $fgets(line, fd);
      if (cnt > 0 && line.len() > 1 && line[0] != "#") begin
        cnt = $sscanf(line,
          "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
          f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10], f[11], f[12],
          f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20], f[21], f[22], f[23],
          f[24], f[25], f[26], f[27], f[28]);
        if (cnt == N_FIELDS) begin
          vec_valid[n_vec] = f[0][N-1:0];
          vec_ctrl[n_vec]  = {f[1][0], f[2][0], f[3][0], f[4][0]};
          for (int r = 0; r < N; r++) begin
            b = 5 + 6 * r;
            // 24-bit address tag widened into distinct host and card windows
            vec_req[n_vec][r].paddr_host = {24'h000010, f[b+4][23:0]};
            vec_req[n_vec][r].paddr_card = {24'h0000c0, f[b+4][23:0]};
            vec_req[n_vec][r].len        = {12'h000, f[b+5][15:0]};
            vec_req[n_vec][r].ctl        = f[b][0];
            vec_req[n_vec][r].pid        = f[b+1][5:0];
            vec_req[n_vec][r].dest       = f[b+2][3:0];
            vec_req[n_vec][r].stream     = f[b+3][0];
          end
          n_vec++;
        end
      end
    end
    $fclose(fd);
    ok = (n_vec > 0);
  endtask

  task automatic drive_vector(input int k);
    req_valid = vec_valid[k];
    for (int r = 0; r < N; r++) begin
      req[r] = vec_req[k][r];
    end
    {host_ready, card_ready, host_done, card_done} = vec_ctrl[k];
    // Card done held back while nothing is outstanding
    card_done = card_done && (outstanding > 0);
  endtask

  task automatic drive_random();
    logic [31:0] rnd;

    rnd = $random(seed);
    req_valid  = rnd[N-1:0];
    // Channels ready about three cycles in four
    host_ready = |rnd[5:4];
    card_ready = |rnd[7:6];
    host_done  = rnd[8];
    card_done  = rnd[9] && (outstanding > 0);
    for (int r = 0; r < N; r++) begin
      rnd = $random(seed);
      req[r].paddr_host = {16'h0010, rnd};
      req[r].paddr_card = {16'h00c0, ~rnd};
      rnd = $random(seed);
      req[r].len    = rnd[27:0];
      req[r].ctl    = rnd[28];
      req[r].stream = rnd[29];
      rnd = $random(seed);
      req[r].pid  = rnd[5:0];
      req[r].dest = rnd[9:6];
    end
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    logic ok;

    load_vectors(ok);
    if (!ok) begin
      $display("Could not read any stimulus from tests/isr_dma_tests.txt");
      $display("Simulation FAILED");
      $finish;
    end else begin
      load_done = 1'b1;
      repeat (RESET_CYCLES) @(posedge aclk);
      @(negedge aclk);
      aresetn = 1'b1;

      for (int k = 0; k < n_vec; k++) begin
        @(negedge aclk);
        drive_vector(k);
      end
      for (int k = 0; k < RANDOM_CYCLES; k++) begin
        @(negedge aclk);
        drive_random();
      end

      @(negedge aclk);
      req_valid = '0;
      host_done = 1'b0;
      card_done = 1'b0;
      repeat (2) @(posedge aclk);

      $display("Errors: %0d", checker_errors);
      if (checker_errors == 0) begin
        $display("Simulation PASSED");
      end else begin
        $display("Simulation FAILED");
      end
      $finish;
    end
  end

  // Run limit from vector count plus random phase and slack
  initial begin
    wait (load_done);
    #((n_vec + RANDOM_CYCLES + 20) * CLK_PERIOD);
    $display("Watchdog expired before the test sequence completed");
    $display("Simulation FAILED");
    $finish;
  end

endmodule
